//--- cache_bank.f
verilog/cache_geom_pkg.sv
verilog/cache_op_pkg.sv
verilog/bank_ifs.sv
verilog/bank_input_arb.sv
verilog/bank_lookup.sv
verilog/bank_data_store.sv
verilog/miss_holder.sv
verilog/mem_req_queue.sv
verilog/cache_bank.sv
tests/cache_bank_properties.sv
tests/cache_bank_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e

verilator --binary --timing --assert -Wno-fatal \
    --top-module cache_bank_tb -f cache_bank.f -o cache_bank_sim

./obj_dir/cache_bank_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Finished with errors" sim.log; then
    exit 1
fi
if ! grep -q "Finished with no errors" sim.log; then
    exit 1
fi
exit 0

//--- tests/cache_bank_vectors.txt
// op(1 read, 2 write) hit(1 = no fill) line_addr wsel byteen wdata tag expected_rdata
// writes first, all misses, pushed against a stalled memory
2_0_010_1_f_aaaa0001_01_00000000
2_0_020_2_3_bbbb0002_02_00000000
2_0_031_0_c_cccc0003_03_00000000
2_0_042_3_f_dddd0004_04_00000000
2_0_053_0_1_eeee0005_05_00000000
1_0_010_1_0_00000000_06_aaaa0001
1_1_010_0_0_00000000_07_00000040
1_1_010_1_0_00000000_08_aaaa0001
2_0_010_2_6_11223344_09_00000000
1_1_010_2_0_00000000_0a_00223342
1_0_020_2_0_00000000_0b_00000002
1_1_020_3_0_00000000_0c_00000083
1_0_031_0_0_00000000_0d_cccc00c4
1_0_121_1_0_00000000_0e_00000485
1_0_031_0_0_00000000_0f_cccc00c4
1_0_042_3_0_00000000_10_dddd0004
2_0_042_3_8_77000000_11_00000000
1_1_042_3_0_00000000_12_77dd0004
1_0_053_0_0_00000000_13_00000105
2_0_053_1_f_0badf00d_14_00000000
2_0_053_2_f_12345678_15_00000000
2_0_053_3_f_9abcdef0_16_00000000
2_0_053_0_f_55aa55aa_17_00000000
1_1_053_1_0_00000000_18_0badf00d
1_1_053_2_0_00000000_19_12345678
1_1_053_3_0_00000000_1a_9abcdef0
1_1_053_0_0_00000000_1b_55aa55aa
1_0_fff_3_0_00000000_1c_00003fff
1_1_fff_0_0_00000000_1d_00003ffc
2_0_0af_1_5_a1b2c3d4_1e_00000000
1_1_fff_3_0_00000000_1f_00003fff
1_0_0af_1_0_00000000_20_00b202d4
1_0_fff_3_0_00000000_21_00003fff
1_1_020_2_0_00000000_22_00000002
1_0_010_1_0_00000000_23_aaaa0001
1_1_010_2_0_00000000_24_00223342

//--- tests/cache_bank_tb.sv
`timescale 1ns/10ps

module cache_bank_tb;
    import cache_geom_pkg::*;
    import cache_op_pkg::*;

    localparam int MAX_VECTORS = 64;
    localparam int CLK_HALF    = 20;

    logic         clk;
    logic         arst_n;
    logic         core_req_valid;
    logic         core_req_rw;
    line_addr_t   core_req_addr;
    word_sel_t    core_req_wsel;
    word_byteen_t core_req_byteen;
    word_t        core_req_data;
    req_tag_t     core_req_tag;
    logic         core_req_ready;
    logic         core_rsp_valid;
    word_t        core_rsp_data;
    req_tag_t     core_rsp_tag;
    logic         mem_req_valid;
    logic         mem_req_rw;
    line_addr_t   mem_req_addr;
    line_t        mem_req_data;
    line_byteen_t mem_req_byteen;
    logic         mem_req_ready;
    logic         mem_rsp_valid;
    line_t        mem_rsp_data;
    logic         mem_rsp_ready;

    // op, hit flag, addr, wsel, byteen, wdata, tag, expected data
    logic [99:0] vectors [MAX_VECTORS];
    int          num_vectors = 0;
    int          cycle = 0;
    logic [15:0] lfsr_state = 16'd75;

    // expected core responses and memory requests, in acceptance order
    req_tag_t     exp_tag_q [$];
    word_t        exp_data_q [$];
    int           exp_edge_q [$];
    logic         exp_rw_q [$];
    line_addr_t   exp_maddr_q [$];
    line_byteen_t exp_mbe_q [$];
    line_t        exp_mdata_q [$];

    line_t mem_lines [line_addr_t];
    int    stall_left = 30;
    int    fill_delay = 0;
    logic  fill_pending = 1'b0;
    line_t fill_line;
    logic  rsp_fire = 1'b0;
    logic  miss_open = 1'b0;

    int   rsp_errors = 0;
    int   mreq_errors = 0;
    int   timing_errors = 0;
    int   other_errors = 0;
    logic saw_alm_full = 1'b0;

    cache_bank cache_bank_i (.*);

    initial clk = 1'b0;
    always #CLK_HALF clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | lfsr_state[15];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // each word holds its line address and word index
    function automatic line_t default_line(input line_addr_t a);
        line_t l;
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            l[w*32 +: 32] = word_t'({a, w[1:0]});
        end
        return l;
    endfunction

    function automatic line_t mem_read(input line_addr_t a);
        return mem_lines.exists(a) ? mem_lines[a] : default_line(a);
    endfunction

    task automatic apply_write(input line_addr_t a, input line_t d, input line_byteen_t be);
        line_t l;
        l = mem_read(a);
        for (int b = 0; b < LINE_SIZE; b++) begin
            if (be[b]) l[b*8 +: 8] = d[b*8 +: 8];
        end
        mem_lines[a] = l;
    endtask

    task automatic report_mismatch(input string name, input logic [127:0] got,
                                   input logic [127:0] expv);
        $display("Fail at %0t: %s got %h expected %h", $time, name, got, expv);
    endtask

    task automatic record_accept(input logic [99:0] v);
        int           edge_n;
        line_byteen_t be;
        edge_n = cycle + 1;
        if (v[99:96] == 4'd1) begin
            exp_tag_q.push_back(req_tag_t'(v[39:32]));
            exp_data_q.push_back(v[31:0]);
            // hit reads answer two edges after acceptance
            exp_edge_q.push_back(v[95:92] != 0 ? edge_n + 2 : -1);
            if (v[95:92] == 0) begin
                miss_open = 1'b1;
                exp_rw_q.push_back(1'b0);
                exp_maddr_q.push_back(v[91:80]);
                exp_mbe_q.push_back('1);
                exp_mdata_q.push_back('0);
            end
        end else begin
            be = '0;
            be[v[77:76]*WORD_SIZE +: WORD_SIZE] = v[75:72];
            exp_rw_q.push_back(1'b1);
            exp_maddr_q.push_back(v[91:80]);
            exp_mbe_q.push_back(be);
            exp_mdata_q.push_back({WORDS_PER_LINE{v[71:40]}});
        end
    endtask

    task automatic drive_vectors();
        logic [99:0] v;
        for (int k = 0; k < num_vectors; k++) begin
            v = vectors[k];
            core_req_valid  = 1'b1;
            core_req_rw     = (v[99:96] == 4'd2);
            core_req_addr   = v[91:80];
            core_req_wsel   = v[77:76];
            core_req_byteen = v[75:72];
            core_req_data   = v[71:40];
            core_req_tag    = req_tag_t'(v[39:32]);
            #1;
            while (!core_req_ready) begin
                @(negedge clk);
                #1;
            end
            record_accept(v);
            @(negedge clk);
        end
        core_req_valid = 1'b0;
    endtask

    task automatic check_mem_req();
        if (exp_rw_q.size() == 0) begin
            other_errors++;
            $display("unexpected memory request at %0t for line %h", $time, mem_req_addr);
        end else begin
            if (mem_req_rw !== exp_rw_q[0]) begin
                mreq_errors++;
                report_mismatch("mem_req_rw", mem_req_rw, exp_rw_q[0]);
            end
            if (mem_req_addr !== exp_maddr_q[0]) begin
                mreq_errors++;
                report_mismatch("mem_req_addr", mem_req_addr, exp_maddr_q[0]);
            end
            if (mem_req_byteen !== exp_mbe_q[0]) begin
                mreq_errors++;
                report_mismatch("mem_req_byteen", mem_req_byteen, exp_mbe_q[0]);
            end
            if (exp_rw_q[0] && mem_req_data !== exp_mdata_q[0]) begin
                mreq_errors++;
                report_mismatch("mem_req_data", mem_req_data, exp_mdata_q[0]);
            end
            void'(exp_rw_q.pop_front());
            void'(exp_maddr_q.pop_front());
            void'(exp_mbe_q.pop_front());
            void'(exp_mdata_q.pop_front());
        end
        if (mem_req_rw) begin
            apply_write(mem_req_addr, mem_req_data, mem_req_byteen);
        end else begin
            fill_line = mem_read(mem_req_addr);
            take_bits(3, fill_delay);
            fill_pending = 1'b1;
        end
    endtask

    // memory model, serves requests in order
    initial begin
        int r;
        int len;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data  = '0;
        forever begin
            @(negedge clk);
            // fill ready belongs to a read miss that waits for its line
            if (mem_rsp_ready && !miss_open) begin
                other_errors++;
                $display("mem_rsp_ready high at %0t with no fill outstanding", $time);
            end
            if (rsp_fire) begin
                mem_rsp_valid = 1'b0;
                miss_open     = 1'b0;
            end
            if (fill_pending) begin
                if (fill_delay > 0) begin
                    fill_delay--;
                end else begin
                    mem_rsp_valid = 1'b1;
                    mem_rsp_data  = fill_line;
                    fill_pending  = 1'b0;
                end
            end
            rsp_fire = mem_rsp_valid && mem_rsp_ready;
            if (stall_left > 0) begin
                stall_left--;
                mem_req_ready = 1'b0;
            end else begin
                take_bits(3, r);
                if (r == 0) begin
                    take_bits(4, len);
                    stall_left = 8 + len;
                end
                mem_req_ready = (r > 1);
            end
            if (arst_n && mem_req_valid && mem_req_ready) begin
                check_mem_req();
            end
        end
    end

    always @(negedge clk) begin
        if (arst_n && core_rsp_valid) begin
            if (exp_tag_q.size() == 0) begin
                other_errors++;
                $display("core response at %0t with no read outstanding", $time);
            end else begin
                if (core_rsp_tag !== exp_tag_q[0]) begin
                    rsp_errors++;
                    report_mismatch("core_rsp_tag", core_rsp_tag, exp_tag_q[0]);
                end
                if (core_rsp_data !== exp_data_q[0]) begin
                    rsp_errors++;
                    report_mismatch("core_rsp_data", core_rsp_data, exp_data_q[0]);
                end
                // the core samples the response on the next rising edge
                if (exp_edge_q[0] >= 0 && cycle + 1 != exp_edge_q[0]) begin
                    timing_errors++;
                    report_mismatch("core_rsp_valid edge", cycle + 1, exp_edge_q[0]);
                end
                void'(exp_tag_q.pop_front());
                void'(exp_data_q.pop_front());
                void'(exp_edge_q.pop_front());
            end
        end
    end

    // queue level seen from inside the DUT
    always @(negedge clk) begin
        if (arst_n) begin
            if (cache_bank_i.mreq_queue.count >= MREQ_ALM_FULL) begin
                saw_alm_full = 1'b1;
                if (core_req_ready) begin
                    other_errors++;
                    $display("core_req_ready high at %0t with the queue almost full", $time);
                end
            end
            if (cache_bank_i.mreq_queue.count == MREQ_DEPTH && cache_bank_i.mreq.push) begin
                other_errors++;
                $display("push into a full memory request queue at %0t", $time);
            end
        end
    end

    initial begin
        #1;
        #(num_vectors * 200 * 40);
        $display("timeout at %0t, the run did not complete", $time);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        arst_n          = 1'b0;
        core_req_valid  = 1'b0;
        core_req_rw     = 1'b0;
        core_req_addr   = '0;
        core_req_wsel   = '0;
        core_req_byteen = '0;
        core_req_data   = '0;
        core_req_tag    = '0;
        for (int i = 0; i < MAX_VECTORS; i++) begin
            vectors[i] = '0;
        end
        $readmemh("tests/cache_bank_vectors.txt", vectors);
        while (num_vectors < MAX_VECTORS && vectors[num_vectors][99:96] != 0) begin
            num_vectors++;
        end
        if (num_vectors == 0) begin
            other_errors++;
            $display("no vectors were read");
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        drive_vectors();
        while (exp_tag_q.size() != 0 || exp_rw_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        if (!saw_alm_full) begin
            other_errors++;
            $display("memory request queue never reached its almost-full level");
        end
        $display("errors: response %0d, memory request %0d, timing %0d, other %0d",
                 rsp_errors, mreq_errors, timing_errors, other_errors);
        if (rsp_errors + mreq_errors + timing_errors + other_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- tests/cache_bank_properties.sv
`timescale 1ns/10ps

module cache_bank_properties (
    input logic                   clk,
    input logic                   arst_n,
    input logic                   st0_valid,
    input cache_op_pkg::bank_op_e st0_op,
    input logic                   hit,
    input logic                   push,
    input logic                   alm_full,
    input logic                   core_rsp_valid
);
    import cache_op_pkg::*;

    int pushes_at_alm_full;

    // pushes that land while the almost-full level holds
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pushes_at_alm_full <= 0;
        end else if (!alm_full) begin
            pushes_at_alm_full <= 0;
        end else if (push) begin
            pushes_at_alm_full <= pushes_at_alm_full + 1;
        end
    end

    // the fill just before the replay made the line valid
    replay_hits: assert property (@(posedge clk) disable iff (!arst_n)
        (st0_valid && st0_op == op_replay) |-> hit)
        else $error("replay in stage 0 missed the cache");

    // only the requests still in the pipe may follow the almost-full level
    no_push_when_full: assert property (@(posedge clk) disable iff (!arst_n)
        (push && alm_full) |-> (pushes_at_alm_full < MREQ_DEPTH - MREQ_ALM_FULL))
        else $error("memory request pushed into a full queue");

    no_rsp_after_write: assert property (@(posedge clk) disable iff (!arst_n)
        core_rsp_valid |-> !$past(st0_valid && st0_op == op_write))
        else $error("core response followed a write");

endmodule

bind bank_lookup cache_bank_properties lookup_props (
    .clk            (clk),
    .arst_n         (arst_n),
    .st0_valid      (st0.valid),
    .st0_op         (st0.op),
    .hit            (hit),
    .push           (mreq.push),
    .alm_full       (mreq.alm_full),
    .core_rsp_valid (core_rsp_valid)
);

//--- verilog/cache_bank.sv
`timescale 1ns/10ps

module cache_bank (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         core_req_valid,
    input  logic                         core_req_rw,
    input  cache_geom_pkg::line_addr_t   core_req_addr,
    input  cache_geom_pkg::word_sel_t    core_req_wsel,
    input  cache_geom_pkg::word_byteen_t core_req_byteen,
    input  cache_geom_pkg::word_t        core_req_data,
    input  cache_geom_pkg::req_tag_t     core_req_tag,
    output logic                         core_req_ready,
    output logic                         core_rsp_valid,
    output cache_geom_pkg::word_t        core_rsp_data,
    output cache_geom_pkg::req_tag_t     core_rsp_tag,
    output logic                         mem_req_valid,
    output logic                         mem_req_rw,
    output cache_geom_pkg::line_addr_t   mem_req_addr,
    output cache_geom_pkg::line_t        mem_req_data,
    output cache_geom_pkg::line_byteen_t mem_req_byteen,
    input  logic                         mem_req_ready,
    input  logic                         mem_rsp_valid,
    input  cache_geom_pkg::line_t        mem_rsp_data,
    output logic                         mem_rsp_ready
);
    import cache_geom_pkg::*;

    logic       replay_valid;
    line_addr_t replay_addr;
    word_sel_t  replay_wsel;
    req_tag_t   replay_tag;
    logic       miss_busy;
    logic       miss_alloc;
    logic       hit;
    word_sel_t  rsp_wsel;

    st0_if  st0 ();
    mreq_if mreq ();

    bank_input_arb input_arb (
        .clk             (clk),
        .arst_n          (arst_n),
        .core_req_valid  (core_req_valid),
        .core_req_rw     (core_req_rw),
        .core_req_addr   (core_req_addr),
        .core_req_wsel   (core_req_wsel),
        .core_req_byteen (core_req_byteen),
        .core_req_data   (core_req_data),
        .core_req_tag    (core_req_tag),
        .core_req_ready  (core_req_ready),
        .mem_rsp_valid   (mem_rsp_valid),
        .mem_rsp_ready   (mem_rsp_ready),
        .mem_rsp_data    (mem_rsp_data),
        .replay_valid    (replay_valid),
        .replay_addr     (replay_addr),
        .replay_wsel     (replay_wsel),
        .replay_tag      (replay_tag),
        .miss_busy       (miss_busy),
        .mreq_alm_full   (mreq.alm_full),
        .st0             (st0)
    );

    bank_lookup lookup (
        .clk            (clk),
        .arst_n         (arst_n),
        .st0            (st0),
        .mreq           (mreq),
        .hit            (hit),
        .miss_alloc     (miss_alloc),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp_tag   (core_rsp_tag),
        .rsp_wsel       (rsp_wsel)
    );

    bank_data_store data_store (
        .clk           (clk),
        .st0           (st0),
        .hit           (hit),
        .rsp_wsel      (rsp_wsel),
        .core_rsp_data (core_rsp_data)
    );

    miss_holder miss (
        .clk           (clk),
        .arst_n        (arst_n),
        .st0           (st0),
        .miss_alloc    (miss_alloc),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_ready (mem_rsp_ready),
        .miss_busy     (miss_busy),
        .replay_valid  (replay_valid),
        .replay_addr   (replay_addr),
        .replay_wsel   (replay_wsel),
        .replay_tag    (replay_tag)
    );

    mem_req_queue mreq_queue (
        .clk            (clk),
        .arst_n         (arst_n),
        .mreq           (mreq),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ready  (mem_req_ready),
        .mem_req_rw     (mem_req_rw),
        .mem_req_addr   (mem_req_addr),
        .mem_req_data   (mem_req_data),
        .mem_req_byteen (mem_req_byteen)
    );

endmodule

//--- verilog/mem_req_queue.sv
`timescale 1ns/10ps

module mem_req_queue (
    input  logic                         clk,
    input  logic                         arst_n,
    mreq_if.queue                        mreq,
    output logic                         mem_req_valid,
    input  logic                         mem_req_ready,
    output logic                         mem_req_rw,
    output cache_geom_pkg::line_addr_t   mem_req_addr,
    output cache_geom_pkg::line_t        mem_req_data,
    output cache_geom_pkg::line_byteen_t mem_req_byteen
);
    import cache_geom_pkg::*;
    import cache_op_pkg::*;

    logic                            rw_q     [MREQ_DEPTH];
    line_addr_t                      addr_q   [MREQ_DEPTH];
    line_t                           data_q   [MREQ_DEPTH];
    line_byteen_t                    byteen_q [MREQ_DEPTH];
    logic [$clog2(MREQ_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(MREQ_DEPTH)-1:0]   rd_ptr;
    logic [$clog2(MREQ_DEPTH+1)-1:0] count;
    logic                            pop;

    assign pop = mem_req_valid & mem_req_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (mreq.push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({mreq.push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (mreq.push) begin
            rw_q[wr_ptr]     <= mreq.rw;
            addr_q[wr_ptr]   <= mreq.addr;
            data_q[wr_ptr]   <= mreq.data;
            byteen_q[wr_ptr] <= mreq.byteen;
        end
    end

    // counts only entries already written, so a push shows a cycle later
    assign mreq.alm_full  = (count >= MREQ_ALM_FULL);
    assign mem_req_valid  = (count != '0);
    assign mem_req_rw     = rw_q[rd_ptr];
    assign mem_req_addr   = addr_q[rd_ptr];
    assign mem_req_data   = data_q[rd_ptr];
    assign mem_req_byteen = byteen_q[rd_ptr];

endmodule

//--- verilog/miss_holder.sv
`timescale 1ns/10ps

module miss_holder (
    input  logic                       clk,
    input  logic                       arst_n,
    st0_if.sink                        st0,
    input  logic                       miss_alloc,
    input  logic                       mem_rsp_valid,
    output logic                       mem_rsp_ready,
    output logic                       miss_busy,
    output logic                       replay_valid,
    output cache_geom_pkg::line_addr_t replay_addr,
    output cache_geom_pkg::word_sel_t  replay_wsel,
    output cache_geom_pkg::req_tag_t   replay_tag
);
    import cache_op_pkg::*;

    miss_state_e state_q;
    miss_state_e state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            miss_idle: begin
                if (miss_alloc) begin
                    state_d = miss_wait_fill;
                end
            end
            // ready is high here, so valid alone means the fill was taken
            miss_wait_fill: begin
                if (mem_rsp_valid) begin
                    state_d = miss_replay;
                end
            end
            miss_replay: state_d = miss_idle;
            default:     state_d = miss_idle;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= miss_idle;
        end else begin
            state_q <= state_d;
        end
    end

    // missed read, kept until its replay
    always_ff @(posedge clk) begin
        if (miss_alloc) begin
            replay_addr <= st0.addr;
            replay_wsel <= st0.wsel;
            replay_tag  <= st0.tag;
        end
    end

    assign mem_rsp_ready = (state_q == miss_wait_fill);
    assign replay_valid  = (state_q == miss_replay);
    assign miss_busy     = (state_q != miss_idle) || miss_alloc;

endmodule

//--- verilog/bank_data_store.sv
`timescale 1ns/10ps

module bank_data_store (
    input  logic                      clk,
    st0_if.sink                       st0,
    input  logic                      hit,
    input  cache_geom_pkg::word_sel_t rsp_wsel,
    output cache_geom_pkg::word_t     core_rsp_data
);
    import cache_geom_pkg::*;
    import cache_op_pkg::*;

    line_t     lines [NUM_LINES];
    line_t     merged;
    line_t     rd_line_q;
    line_idx_t idx;
    logic      do_fill;
    logic      do_write;

    assign idx      = st0.addr[LINE_SEL_BITS-1:0];
    assign do_fill  = st0.valid && (st0.op == op_fill);
    // write misses leave the array alone
    assign do_write = st0.valid && (st0.op == op_write) && hit;

    always_comb begin
        merged = lines[idx];
        for (int b = 0; b < WORD_SIZE; b++) begin
            if (st0.byteen[b]) begin
                merged[(st0.wsel*WORD_SIZE + b)*8 +: 8] = st0.wdata[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_fill) begin
            lines[idx] <= st0.wdata;
        end else if (do_write) begin
            lines[idx] <= merged;
        end
        rd_line_q <= lines[idx];
    end

    // word picked with the stage-1 word select
    assign core_rsp_data = rd_line_q[rsp_wsel*8*WORD_SIZE +: 8*WORD_SIZE];

endmodule

//--- verilog/bank_lookup.sv
`timescale 1ns/10ps

module bank_lookup (
    input  logic                      clk,
    input  logic                      arst_n,
    st0_if.sink                       st0,
    mreq_if.src                       mreq,
    output logic                      hit,
    output logic                      miss_alloc,
    output logic                      core_rsp_valid,
    output cache_geom_pkg::req_tag_t  core_rsp_tag,
    output cache_geom_pkg::word_sel_t rsp_wsel
);
    import cache_geom_pkg::*;
    import cache_op_pkg::*;

    logic [NUM_LINES-1:0] valid_q;
    line_tag_t            tags_q [NUM_LINES];
    line_idx_t            idx_st0;
    line_tag_t            tag_st0;
    logic                 do_fill;

    // stage-1 register
    logic         rsp_st1;
    logic         fill_req_st1;
    logic         wt_req_st1;
    line_addr_t   addr_st1;
    word_sel_t    wsel_st1;
    word_byteen_t byteen_st1;
    word_t        word_st1;
    req_tag_t     tag_st1;
    line_byteen_t wt_byteen;

    assign idx_st0 = st0.addr[LINE_SEL_BITS-1:0];
    assign tag_st0 = st0.addr[LINE_ADDR_WIDTH-1 -: TAG_SEL_BITS];
    assign do_fill = st0.valid && (st0.op == op_fill);

    assign hit        = valid_q[idx_st0] && (tags_q[idx_st0] == tag_st0);
    assign miss_alloc = st0.valid && (st0.op == op_read) && !hit;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else if (do_fill) begin
            valid_q[idx_st0] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_fill) begin
            tags_q[idx_st0] <= tag_st0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_st1      <= 1'b0;
            fill_req_st1 <= 1'b0;
            wt_req_st1   <= 1'b0;
        end else begin
            // replays land here after their fill, so they respond like hits
            rsp_st1      <= st0.valid && hit && (st0.op == op_read || st0.op == op_replay);
            fill_req_st1 <= miss_alloc;
            // write-through on hit and miss alike, no allocate
            wt_req_st1   <= st0.valid && (st0.op == op_write);
        end
    end

    always_ff @(posedge clk) begin
        addr_st1   <= st0.addr;
        wsel_st1   <= st0.wsel;
        byteen_st1 <= st0.byteen;
        word_st1   <= st0.wdata[8*WORD_SIZE-1:0];
        tag_st1    <= st0.tag;
    end

    // byte enables only in the selected word slot
    always_comb begin
        wt_byteen = '0;
        wt_byteen[wsel_st1*WORD_SIZE +: WORD_SIZE] = byteen_st1;
    end

    assign core_rsp_valid = rsp_st1;
    assign core_rsp_tag   = tag_st1;
    assign rsp_wsel       = wsel_st1;

    assign mreq.push   = fill_req_st1 | wt_req_st1;
    assign mreq.rw     = wt_req_st1;
    assign mreq.addr   = addr_st1;
    assign mreq.data   = {WORDS_PER_LINE{word_st1}};
    assign mreq.byteen = wt_req_st1 ? wt_byteen : '1;

endmodule

//--- verilog/bank_input_arb.sv
`timescale 1ns/10ps

module bank_input_arb (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         core_req_valid,
    input  logic                         core_req_rw,
    input  cache_geom_pkg::line_addr_t   core_req_addr,
    input  cache_geom_pkg::word_sel_t    core_req_wsel,
    input  cache_geom_pkg::word_byteen_t core_req_byteen,
    input  cache_geom_pkg::word_t        core_req_data,
    input  cache_geom_pkg::req_tag_t     core_req_tag,
    output logic                         core_req_ready,
    input  logic                         mem_rsp_valid,
    input  logic                         mem_rsp_ready,
    input  cache_geom_pkg::line_t        mem_rsp_data,
    input  logic                         replay_valid,
    input  cache_geom_pkg::line_addr_t   replay_addr,
    input  cache_geom_pkg::word_sel_t    replay_wsel,
    input  cache_geom_pkg::req_tag_t     replay_tag,
    input  logic                         miss_busy,
    input  logic                         mreq_alm_full,
    st0_if.arb                           st0
);
    import cache_geom_pkg::*;
    import cache_op_pkg::*;

    logic         fill_fire;
    logic         core_fire;
    logic         sel_valid;
    bank_op_e     sel_op;
    line_addr_t   sel_addr;
    word_sel_t    sel_wsel;
    word_byteen_t sel_byteen;
    line_t        sel_wdata;
    req_tag_t     sel_tag;

    // replay first, then fill, then the core
    assign fill_fire      = ~replay_valid & mem_rsp_valid & mem_rsp_ready;
    assign core_req_ready = ~replay_valid & ~fill_fire & ~miss_busy & ~mreq_alm_full;
    assign core_fire      = core_req_valid & core_req_ready;
    assign sel_valid      = replay_valid | fill_fire | core_fire;

    always_comb begin
        sel_op     = core_req_rw ? op_write : op_read;
        sel_addr   = core_req_addr;
        sel_wsel   = core_req_wsel;
        sel_byteen = core_req_byteen;
        sel_wdata  = line_t'(core_req_data);
        sel_tag    = core_req_tag;
        if (replay_valid) begin
            sel_op   = op_replay;
            sel_addr = replay_addr;
            sel_wsel = replay_wsel;
            sel_tag  = replay_tag;
        end else if (fill_fire) begin
            // fill line address comes from the held miss
            sel_op    = op_fill;
            sel_addr  = replay_addr;
            sel_wdata = mem_rsp_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            st0.valid <= 1'b0;
        end else begin
            st0.valid <= sel_valid;
        end
    end

    always_ff @(posedge clk) begin
        st0.op     <= sel_op;
        st0.addr   <= sel_addr;
        st0.wsel   <= sel_wsel;
        st0.byteen <= sel_byteen;
        st0.wdata  <= sel_wdata;
        st0.tag    <= sel_tag;
    end

endmodule

//--- verilog/bank_ifs.sv
`timescale 1ns/10ps

// stage-0 register contents, advances every cycle
interface st0_if;
    import cache_geom_pkg::*;
    import cache_op_pkg::*;

    logic         valid;
    bank_op_e     op;
    line_addr_t   addr;
    word_sel_t    wsel;
    word_byteen_t byteen;
    // write word sits in the low word, a fill uses the whole line
    line_t        wdata;
    req_tag_t     tag;

    modport arb  (output valid, op, addr, wsel, byteen, wdata, tag);
    modport sink (input  valid, op, addr, wsel, byteen, wdata, tag);
endinterface

// push side of the memory request queue
interface mreq_if;
    import cache_geom_pkg::*;

    logic         push;
    logic         rw;
    line_addr_t   addr;
    line_t        data;
    line_byteen_t byteen;
    logic         alm_full;

    modport src   (output push, rw, addr, data, byteen, input alm_full);
    modport queue (input  push, rw, addr, data, byteen, output alm_full);
endinterface

//--- verilog/cache_op_pkg.sv
package cache_op_pkg;

    // kind of operation held in stage 0
    typedef enum logic [1:0] {
        op_read,
        op_write,
        op_fill,
        op_replay
    } bank_op_e;

    typedef enum logic [1:0] {
        miss_idle,
        miss_wait_fill,
        miss_replay
    } miss_state_e;

    // memory request queue sizing
    localparam int MREQ_DEPTH      = 4;
    localparam int PIPELINE_STAGES = 2;
    // leaves room for the requests still in the pipe
    localparam int MREQ_ALM_FULL   = MREQ_DEPTH - PIPELINE_STAGES;

endpackage

//--- verilog/cache_geom_pkg.sv
package cache_geom_pkg;

    // bank capacity and line layout, all in bytes
    localparam int CACHE_SIZE = 256;
    localparam int LINE_SIZE  = 16;
    localparam int WORD_SIZE  = 4;

    localparam int NUM_LINES      = CACHE_SIZE / LINE_SIZE;
    localparam int WORDS_PER_LINE = LINE_SIZE / WORD_SIZE;

    // line address splits into stored tag (high) and line index (low)
    localparam int LINE_ADDR_WIDTH = 12;
    localparam int LINE_SEL_BITS   = $clog2(NUM_LINES);
    localparam int TAG_SEL_BITS    = LINE_ADDR_WIDTH - LINE_SEL_BITS;
    localparam int WORD_SEL_BITS   = $clog2(WORDS_PER_LINE);
    localparam int REQ_TAG_WIDTH   = 6;

    typedef logic [LINE_ADDR_WIDTH-1:0] line_addr_t;
    typedef logic [LINE_SEL_BITS-1:0]   line_idx_t;
    typedef logic [TAG_SEL_BITS-1:0]    line_tag_t;
    typedef logic [WORD_SEL_BITS-1:0]   word_sel_t;
    typedef logic [8*WORD_SIZE-1:0]     word_t;
    typedef logic [WORD_SIZE-1:0]       word_byteen_t;
    typedef logic [8*LINE_SIZE-1:0]     line_t;
    typedef logic [LINE_SIZE-1:0]       line_byteen_t;
    typedef logic [REQ_TAG_WIDTH-1:0]   req_tag_t;

endpackage
